// File: psram_pkg.sv
/* PSRAM controller shared definitions */

package psram_pkg;

	// Bus and data widths
	localparam int ADDR_W = 25;
	localparam int DATA_W = 16;

	// One step is four clk phases
	localparam int PHASES = 4;

	// 150 us and 400 ns at 48 MHz
	localparam int STARTUP_CYCLES = 7200;
	localparam int RESET_DELAY_CYCLES = 20;

	// Step counts per command
	localparam logic [4:0] STEPS_RESET = 5'd3;
	localparam logic [4:0] STEPS_WRLAT = 5'd8;
	localparam logic [4:0] STEPS_RDMEM = 5'd15;
	localparam logic [4:0] STEPS_WRMEM = 5'd18;

	// First step that carries burst data
	localparam logic [4:0] FIRST_DATA_STEP = 5'd10;

	// Burst lengths in 16-bit words
	localparam int WR_WORDS = 8;
	localparam int RD_WORDS = 4;

	// Bus command bytes
	localparam logic [7:0] OPC_RESET_EN = 8'h66;
	localparam logic [7:0] OPC_RESET = 8'h99;
	localparam logic [7:0] OPC_WRITE_EN = 8'h06;
	localparam logic [7:0] OPC_WRITE_REG = 8'h71;
	localparam logic [7:0] OPC_READ = 8'hEE;
	localparam logic [7:0] OPC_WRITE = 8'hDE;

	// Latency 3 setting
	localparam logic [15:0] CR0_VALUE = 16'h8FEF;

	typedef enum logic [1:0] {
		OP_RESET,
		OP_WRLAT,
		OP_RDMEM,
		OP_WRMEM
	} cmd_op_t;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_STARTUP,
		ST_RESET,
		ST_RESET_DELAY,
		ST_CONFIG,
		ST_READY,
		ST_READ,
		ST_WRITE
	} seq_state_t;

	typedef struct packed {
		logic valid;
		cmd_op_t op;
		logic [ADDR_W-1:0] addr;
	} launch_t;

	// Per-phase values of one step, index is the phase
	typedef struct packed {
		logic [3:0] sclk;
		logic [3:0] cs;
		logic [3:0] doe;
		logic [3:0] rwds;
		logic [3:0] rwds_oe;
		logic [3:0][7:0] data;
		logic [3:0][1:0] le;
		logic last;
		logic wrdy;
	} step_wave_t;

	typedef struct packed {
		logic [7:0] data;
		logic data_oe;
		logic [1:0] le;
		logic sclk;
		logic cs;
		logic rwds;
		logic rwds_oe;
	} pad_out_t;

endpackage

// File: psram_sequencer.sv
/* PSRAM start-up and dispatch sequencer */

module psram_sequencer (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         done,
	input  logic [psram_pkg::ADDR_W-1:0] awaddr,
	input  logic [psram_pkg::ADDR_W-1:0] araddr,
	input  logic                         awvalid,
	input  logic                         arvalid,
	output logic                         awready,
	output logic                         arready,
	output logic                         bvalid,
	output logic                         psram_ready,
	output psram_pkg::launch_t           launch
);

	psram_pkg::seq_state_t state;
	logic [12:0] delay;

	function automatic psram_pkg::launch_t make_launch(
		input psram_pkg::cmd_op_t op,
		input logic [psram_pkg::ADDR_W-1:0] addr
	);
		psram_pkg::launch_t l;
		l.valid = 1'b1;
		l.op = op;
		l.addr = addr;
		return l;
	endfunction

	// Writes win over reads
	assign awready = (state == psram_pkg::ST_READY) && awvalid;
	assign arready = (state == psram_pkg::ST_READY) && arvalid && !awvalid;

	////////////////////////////////////////////////////////////
	// Delay counter for startup and post-reset wait

	always_ff @(posedge clk) begin
		if (reset) begin
			delay <= '0;
		end else if (state == psram_pkg::ST_IDLE) begin
			delay <= 13'(psram_pkg::STARTUP_CYCLES);
		end else if (state == psram_pkg::ST_RESET && done) begin
			delay <= 13'(psram_pkg::RESET_DELAY_CYCLES);
		end else if (delay != 13'd0) begin
			delay <= delay - 13'd1;
		end
	end

	////////////////////////////////////////////////////////////
	// Main state machine

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= psram_pkg::ST_IDLE;
			launch <= '0;
		end else begin
			// Launch is a single-cycle pulse
			launch.valid <= 1'b0;
			case (state)
				psram_pkg::ST_IDLE: state <= psram_pkg::ST_STARTUP;
				psram_pkg::ST_STARTUP: if (delay == 13'd0) begin
					state <= psram_pkg::ST_RESET;
					launch <= make_launch(psram_pkg::OP_RESET, '0);
				end
				psram_pkg::ST_RESET: if (done) state <= psram_pkg::ST_RESET_DELAY;
				psram_pkg::ST_RESET_DELAY: if (delay == 13'd0) begin
					state <= psram_pkg::ST_CONFIG;
					launch <= make_launch(psram_pkg::OP_WRLAT, '0);
				end
				psram_pkg::ST_CONFIG: if (done) state <= psram_pkg::ST_READY;
				psram_pkg::ST_READY: begin
					if (awvalid) begin
						state <= psram_pkg::ST_WRITE;
						launch <= make_launch(psram_pkg::OP_WRMEM, awaddr);
					end else if (arvalid) begin
						state <= psram_pkg::ST_READ;
						launch <= make_launch(psram_pkg::OP_RDMEM, araddr);
					end
				end
				psram_pkg::ST_READ: if (done) state <= psram_pkg::ST_READY;
				psram_pkg::ST_WRITE: if (done) state <= psram_pkg::ST_READY;
				default: state <= psram_pkg::ST_IDLE;
			endcase
		end
	end

	// Status and write response
	always_ff @(posedge clk) begin
		if (reset) begin
			psram_ready <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			psram_ready <= psram_ready | (state == psram_pkg::ST_READY);
			bvalid <= (state == psram_pkg::ST_WRITE) && done;
		end
	end

	// A grant goes to one port only and lasts one cycle
	a_grant_pulse: assert property (@(posedge clk) disable iff (reset)
		(awready || arready) |-> !(awready && arready) ##1 !(awready || arready));

	// Engine must finish before the next command goes out
	a_no_overlap: assert property (@(posedge clk) disable iff (reset)
		launch.valid |=> (!launch.valid throughout done [->1]));

endmodule

// File: psram_wave_table.sv
/* PSRAM command waveform table */

module psram_wave_table (
	input  psram_pkg::cmd_op_t           op,
	input  logic [4:0]                   step,
	input  logic [psram_pkg::ADDR_W-1:0] addr,
	input  logic [psram_pkg::DATA_W-1:0] wdata,
	output psram_pkg::step_wave_t        wave
);

	logic [31:0] cmd_addr;
	logic [3:0][7:0] addr_bytes;
	logic frame;
	logic drive;
	logic wr_beat;
	logic [3:0][7:0] bytes;
	logic [3:0][1:0] le;
	logic last;
	logic wrdy;

	// First byte on the rising edge, second on the falling edge
	function automatic logic [3:0][7:0] ddr(input logic [7:0] first, input logic [7:0] second);
		return {second, second, first, first};
	endfunction

	// Reads fetch 8-byte blocks, writes 16-byte blocks
	assign cmd_addr = (op == psram_pkg::OP_WRMEM) ? {7'd0, addr[24:4], 4'd0}
		: {7'd0, addr[24:3], 3'd0};
	assign addr_bytes = (step == 5'd1) ? ddr(cmd_addr[31:24], cmd_addr[23:16])
		: ddr(cmd_addr[15:8], cmd_addr[7:0]);

	always_comb begin
		frame = 1'b0;
		drive = 1'b0;
		wr_beat = 1'b0;
		bytes = '0;
		le = '0;
		last = 1'b0;
		wrdy = 1'b0;
		case (op)
			psram_pkg::OP_RESET: begin
				// Reset enable, CS gap, reset
				frame = (step != 5'd1);
				drive = frame;
				if (step == 5'd0)
					bytes = ddr(psram_pkg::OPC_RESET_EN, psram_pkg::OPC_RESET_EN);
				else
					bytes = ddr(psram_pkg::OPC_RESET, psram_pkg::OPC_RESET);
				last = (step == psram_pkg::STEPS_RESET - 5'd1);
			end
			psram_pkg::OP_WRLAT: begin
				// Write enable on both sides of the CR0 write
				frame = (step != 5'd1) && (step != 5'd6);
				drive = frame;
				case (step)
					5'd0, 5'd7: bytes = ddr(psram_pkg::OPC_WRITE_EN, psram_pkg::OPC_WRITE_EN);
					5'd2: bytes = ddr(psram_pkg::OPC_WRITE_REG, psram_pkg::OPC_WRITE_REG);
					5'd4: bytes = ddr(8'h00, 8'h04);
					5'd5: bytes = ddr(psram_pkg::CR0_VALUE[15:8], psram_pkg::CR0_VALUE[7:0]);
					default: bytes = '0;
				endcase
				last = (step == psram_pkg::STEPS_WRLAT - 5'd1);
			end
			psram_pkg::OP_RDMEM: begin
				// Last step only closes the frame and drains LE1
				frame = (step < psram_pkg::STEPS_RDMEM - 5'd1);
				drive = (step < 5'd3);
				if (step == 5'd0)
					bytes = ddr(psram_pkg::OPC_READ, psram_pkg::OPC_READ);
				else if (step < 5'd3)
					bytes = addr_bytes;
				if (step >= psram_pkg::FIRST_DATA_STEP &&
					step < psram_pkg::FIRST_DATA_STEP + 5'(psram_pkg::RD_WORDS))
					le[2] = 2'b01;
				if (step > psram_pkg::FIRST_DATA_STEP &&
					step <= psram_pkg::FIRST_DATA_STEP + 5'(psram_pkg::RD_WORDS))
					le[0] = 2'b10;
				last = (step == psram_pkg::STEPS_RDMEM - 5'd1);
			end
			psram_pkg::OP_WRMEM: begin
				frame = (step < psram_pkg::STEPS_WRMEM);
				wr_beat = (step >= psram_pkg::FIRST_DATA_STEP) &&
					(step < psram_pkg::FIRST_DATA_STEP + 5'(psram_pkg::WR_WORDS));
				drive = (step < 5'd3) || wr_beat;
				// Ask for the next word one step ahead of its beat
				wrdy = (step >= psram_pkg::FIRST_DATA_STEP - 5'd1) &&
					(step < psram_pkg::FIRST_DATA_STEP + 5'(psram_pkg::WR_WORDS) - 5'd1);
				if (step == 5'd0)
					bytes = ddr(psram_pkg::OPC_WRITE, psram_pkg::OPC_WRITE);
				else if (step < 5'd3)
					bytes = addr_bytes;
				else if (wr_beat)
					bytes = ddr(wdata[15:8], wdata[7:0]);
				last = (step == psram_pkg::STEPS_WRMEM - 5'd1);
			end
			default: begin
			end
		endcase
	end

	always_comb begin
		wave.sclk = frame ? 4'b0110 : 4'b0000;
		wave.cs = {4{frame}};
		wave.doe = {4{drive}};
		// rwds low as write mask, all bytes written
		wave.rwds = 4'b0000;
		wave.rwds_oe = {4{wr_beat}};
		wave.data = bytes;
		wave.le = le;
		wave.last = last;
		wave.wrdy = wrdy;
	end

endmodule

// File: psram_step_engine.sv
/* PSRAM command step engine */

module psram_step_engine (
	input  logic                         clk,
	input  logic                         reset,
	input  psram_pkg::launch_t           launch,
	input  logic [psram_pkg::DATA_W-1:0] wdata,
	output psram_pkg::step_wave_t        wave,
	output logic [1:0]                   phase,
	output logic                         done,
	output logic                         wready
);

	logic busy;
	logic busy_d;
	psram_pkg::cmd_op_t op_q;
	psram_pkg::cmd_op_t op_d;
	logic [psram_pkg::ADDR_W-1:0] addr_q;
	logic [psram_pkg::ADDR_W-1:0] addr_d;
	logic [4:0] step_q;
	logic [4:0] step_d;
	logic [1:0] phase_d;
	logic [psram_pkg::DATA_W-1:0] wdata_q;
	logic [psram_pkg::DATA_W-1:0] wdata_sel;
	logic last_phase;
	psram_pkg::step_wave_t row;

	assign last_phase = (phase == 2'(psram_pkg::PHASES - 1));
	assign done = busy && last_phase && wave.last;
	assign wready = busy && last_phase && wave.wrdy;

	// Live word while it is handed over, held copy for the rest of the beat
	assign wdata_sel = wready ? wdata : wdata_q;

	always_comb begin
		busy_d = busy;
		op_d = op_q;
		addr_d = addr_q;
		step_d = step_q;
		phase_d = busy ? phase + 2'd1 : 2'd0;
		if (launch.valid) begin
			busy_d = 1'b1;
			op_d = launch.op;
			addr_d = launch.addr;
			step_d = 5'd0;
			phase_d = 2'd0;
		end else if (done) begin
			busy_d = 1'b0;
			step_d = 5'd0;
		end else if (busy && last_phase) begin
			step_d = step_q + 5'd1;
		end
	end

	// Row for the step of the coming cycle
	psram_wave_table u_table (
		.op   (op_d),
		.step (step_d),
		.addr (addr_d),
		.wdata(wdata_sel),
		.wave (row)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			step_q <= '0;
			phase <= '0;
			wave <= '0;
		end else begin
			busy <= busy_d;
			step_q <= step_d;
			phase <= phase_d;
			wave <= busy_d ? row : '0;
		end
	end

	always_ff @(posedge clk) begin
		op_q <= op_d;
		addr_q <= addr_d;
		if (wready)
			wdata_q <= wdata;
	end

	a_phase_wrap: assert property (@(posedge clk) disable iff (reset)
		(phase == 2'd0) && ($past(phase) != 2'd0) |-> ($past(phase) == 2'd3));

endmodule

// File: psram_phase_serializer.sv
/* PSRAM pad phase serializer */

module psram_phase_serializer (
	input  logic                  clk,
	input  logic                  reset,
	input  psram_pkg::step_wave_t wave,
	input  logic [1:0]            phase,
	output psram_pkg::pad_out_t   pads
);

	psram_pkg::pad_out_t pads_d;

	// Slice out the current phase of the step row
	always_comb begin
		pads_d.data = wave.data[phase];
		pads_d.data_oe = wave.doe[phase];
		pads_d.le = wave.le[phase];
		pads_d.sclk = wave.sclk[phase];
		pads_d.cs = wave.cs[phase];
		pads_d.rwds = wave.rwds[phase];
		pads_d.rwds_oe = wave.rwds_oe[phase];
	end

	// Registered straight to the pads
	always_ff @(posedge clk) begin
		if (reset) begin
			pads <= '0;
		end else begin
			pads <= pads_d;
		end
	end

endmodule

// File: psram_read_capture.sv
/* PSRAM read data capture */

module psram_read_capture (
	input  logic        clk,
	input  logic        reset,
	input  logic [1:0]  spi_le_in,
	input  logic [7:0]  spi_data_in,
	input  logic        spi_rwds_in,
	output logic [17:0] rdata,
	output logic        rvalid
);

	logic [1:0] le_q;
	logic [8:0] byte_q;
	logic [8:0] first_q;

	// Input registers
	always_ff @(posedge clk) begin
		if (reset) begin
			le_q <= '0;
		end else begin
			le_q <= spi_le_in;
		end
	end

	// {rwds, byte} pairs, first half held until LE1
	always_ff @(posedge clk) begin
		byte_q <= {spi_rwds_in, spi_data_in};
		if (le_q[0])
			first_q <= byte_q;
	end

	assign rdata = {first_q, byte_q};
	assign rvalid = le_q[1];

endmodule

// File: psram_ctrl.sv
/* PSRAM controller top level */

module psram_ctrl (
	input  logic                         clk,
	input  logic                         reset,
	output psram_pkg::pad_out_t          pads,
	input  logic [1:0]                   spi_le_in,
	input  logic [7:0]                   spi_data_in,
	input  logic                         spi_rwds_in,
	output logic                         psram_ready,
	input  logic [psram_pkg::DATA_W-1:0] wdata,
	output logic                         wready,
	input  logic [psram_pkg::ADDR_W-1:0] awaddr,
	input  logic                         awvalid,
	output logic                         awready,
	output logic                         bvalid,
	input  logic [psram_pkg::ADDR_W-1:0] araddr,
	input  logic                         arvalid,
	output logic                         arready,
	output logic [17:0]                  rdata,
	output logic                         rvalid
);

	psram_pkg::launch_t launch;
	psram_pkg::step_wave_t wave;
	logic [1:0] phase;
	logic done;

	psram_sequencer u_seq (
		.clk(clk), .reset(reset), .done(done),
		.awaddr(awaddr), .araddr(araddr), .awvalid(awvalid), .arvalid(arvalid),
		.awready(awready), .arready(arready), .bvalid(bvalid),
		.psram_ready(psram_ready), .launch(launch)
	);

	psram_step_engine u_engine (
		.clk(clk), .reset(reset), .launch(launch), .wdata(wdata),
		.wave(wave), .phase(phase), .done(done), .wready(wready)
	);

	psram_phase_serializer u_ser (
		.clk(clk), .reset(reset), .wave(wave), .phase(phase), .pads(pads)
	);

	psram_read_capture u_capture (
		.clk(clk), .reset(reset), .spi_le_in(spi_le_in), .spi_data_in(spi_data_in),
		.spi_rwds_in(spi_rwds_in), .rdata(rdata), .rvalid(rvalid)
	);

endmodule

// File: psram_model.sv
/* PSRAM bus model */

module psram_model (
	input  logic                clk,
	input  logic                reset,
	input  psram_pkg::pad_out_t pads,
	output logic [1:0]          spi_le_in,
	output logic [7:0]          spi_data_in,
	output logic                spi_rwds_in
);

	timeunit 1ns;
	timeprecision 1ps;

	logic [15:0] mem [int unsigned];
	logic [7:0] cmd_log [$];
	logic [7:0] cfg_bytes [$];

	logic prev_sclk;
	int byte_cnt;
	logic [7:0] cmd;
	logic [15:0] addr_acc;
	logic [7:0] hi_byte;
	logic [22:0] base_word;
	logic [22:0] rd_ptr;
	logic [15:0] cur_word;

	// Unwritten words read back as a pattern of their address
	function automatic logic [15:0] read_mem(input logic [22:0] wa);
		if (mem.exists(wa))
			return mem[wa];
		return wa[15:0] ^ {9'h0A5, wa[22:16]};
	endfunction

	// Strobes come straight back, high byte on LE0 and low byte on LE1
	assign spi_le_in = pads.le;
	assign spi_rwds_in = 1'b0;
	assign spi_data_in = (pads.le == 2'b10) ? cur_word[7:0] : cur_word[15:8];

	////////////////////////////////////////////////////////////
	// Frame decoder, one byte per serial clock edge

	always @(posedge clk) begin
		logic [7:0] b;
		logic [23:0] full;
		int d;
		b = pads.data;
		full = {addr_acc, b};
		d = byte_cnt - 6;
		if (reset) begin
			prev_sclk <= 1'b0;
			byte_cnt <= 0;
		end else begin
			prev_sclk <= pads.sclk;
			if (!pads.cs) begin
				byte_cnt <= 0;
			end else if (pads.sclk != prev_sclk && pads.data_oe) begin
				byte_cnt <= byte_cnt + 1;
				// Byte 1 repeats the command, byte 2 is the dropped top address byte
				if (byte_cnt == 0) begin
					cmd <= b;
					cmd_log.push_back(b);
				end else if (byte_cnt == 3 || byte_cnt == 4) begin
					addr_acc <= {addr_acc[7:0], b};
				end else if (byte_cnt == 5) begin
					base_word <= full[23:1];
					if (cmd == psram_pkg::OPC_READ) begin
						rd_ptr <= full[23:1];
						cur_word <= read_mem(full[23:1]);
					end
				end else if (byte_cnt >= 6) begin
					if (cmd == psram_pkg::OPC_WRITE && !d[0])
						hi_byte <= b;
					else if (cmd == psram_pkg::OPC_WRITE)
						mem[base_word + 23'(d / 2)] = {hi_byte, b};
					else if (cmd == psram_pkg::OPC_WRITE_REG)
						cfg_bytes.push_back(b);
				end
			end
			// Next word once the low byte is out
			if (pads.le == 2'b10) begin
				rd_ptr <= rd_ptr + 23'd1;
				cur_word <= read_mem(rd_ptr + 23'd1);
			end
		end
	end

endmodule

// File: tb_psram_ctrl.sv
/* PSRAM controller testbench */

module tb_psram_ctrl;

	timeunit 1ns;
	timeprecision 1ps;

	typedef enum logic [1:0] {
		K_WRITE,
		K_READ,
		K_BOTH
	} kind_t;

	// One operation of the stimulus table
	typedef struct packed {
		kind_t kind;
		logic rand_addr;
		logic [23:0] addr;
		logic [15:0] seed;
	} op_row_t;

	localparam int RAND_PAIRS = 4;

	logic clk;
	logic reset;
	psram_pkg::pad_out_t pads;
	logic [1:0] spi_le_in;
	logic [7:0] spi_data_in;
	logic spi_rwds_in;
	logic psram_ready;
	logic [15:0] wdata;
	logic wready;
	logic [24:0] awaddr;
	logic awvalid;
	logic awready;
	logic bvalid;
	logic [24:0] araddr;
	logic arvalid;
	logic arready;
	logic [17:0] rdata;
	logic rvalid;

	op_row_t rows [$];
	string names [$];
	logic [15:0] sb [int unsigned];
	logic [15:0] lfsr;
	int checks = 0;
	int errors = 0;
	int bvalid_total = 0;
	int rvalid_total = 0;
	logic ready_seen = 1'b0;
	logic table_done = 1'b0;

	psram_ctrl dut_i (
		.clk(clk), .reset(reset), .pads(pads),
		.spi_le_in(spi_le_in), .spi_data_in(spi_data_in), .spi_rwds_in(spi_rwds_in),
		.psram_ready(psram_ready), .wdata(wdata), .wready(wready),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready), .bvalid(bvalid),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rvalid(rvalid)
	);

	psram_model model_i (
		.clk(clk), .reset(reset), .pads(pads),
		.spi_le_in(spi_le_in), .spi_data_in(spi_data_in), .spi_rwds_in(spi_rwds_in)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Monitors and watchdog

	always @(posedge clk) begin
		if (!reset) begin
			if (bvalid)
				bvalid_total++;
			if (rvalid)
				rvalid_total++;
			if (ready_seen && !psram_ready) begin
				errors++;
				$display("psram_ready fell after it had risen");
			end
			if (psram_ready)
				ready_seen <= 1'b1;
		end
	end

	initial begin
		wait (table_done);
		repeat (psram_pkg::STARTUP_CYCLES + 100 * rows.size()) @(posedge clk);
		$display("Watchdog expired, the controller stopped responding");
		$display("TESTS FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Helpers

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("FAILED %s: expected 0x%0h, actual 0x%0h", what, expected, actual);
		end
	endtask

	// Galois LFSR x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic random_bits(input int n, output logic [23:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[22:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	task automatic add_row(input string name, input kind_t kind, input logic rnd,
		input logic [23:0] addr, input logic [15:0] seed);
		op_row_t r;
		r.kind = kind;
		r.rand_addr = rnd;
		r.addr = addr;
		r.seed = seed;
		rows.push_back(r);
		names.push_back(name);
	endtask

	task automatic build_table();
		add_row("write block A", K_WRITE, 1'b0, 24'h001230, 16'h1000);
		add_row("read block A low", K_READ, 1'b0, 24'h001230, 16'h0000);
		add_row("read block A high", K_READ, 1'b0, 24'h001238, 16'h0000);
		add_row("write and read together", K_BOTH, 1'b0, 24'h004560, 16'h2200);
		add_row("read unaligned A", K_READ, 1'b0, 24'h00123D, 16'h0000);
		add_row("read unaligned B", K_READ, 1'b0, 24'h004563, 16'h0000);
		for (int i = 0; i < RAND_PAIRS; i++) begin
			add_row($sformatf("random write %0d", i), K_WRITE, 1'b1, '0, 16'h3000 + 16'(i * 256));
			add_row($sformatf("random read %0d", i), K_READ, 1'b1, '0, 16'h0000);
		end
	endtask

	// Raise the valids and wait for the grant of the winning port
	task automatic send_request(input string name, input logic wr, input logic rd,
		input logic [23:0] addr, input logic [15:0] seed);
		@(posedge clk);
		awaddr <= {1'b0, addr};
		araddr <= {1'b0, addr};
		awvalid <= wr;
		arvalid <= rd;
		wdata <= seed;
		do begin
			@(posedge clk);
		end while (!(wr ? awready : arready));
		if (wr) begin
			awvalid <= 1'b0;
			check_value($sformatf("%s arready at write grant", name), 0, arready);
		end else begin
			arvalid <= 1'b0;
		end
	endtask

	// Feed the burst words until bvalid, or until arready when a read waits
	task automatic serve_write(input string name, input logic [23:0] addr,
		input logic [15:0] seed, input logic read_waits);
		int beats;
		int bresp;
		logic [22:0] base;
		beats = 0;
		bresp = 0;
		base = {addr[23:4], 3'b000};
		do begin
			@(posedge clk);
			if (wready) begin
				beats++;
				wdata <= seed + 16'(beats);
			end
			if (bvalid)
				bresp++;
		end while (!(read_waits ? arready : bvalid));
		check_value($sformatf("%s wready pulses", name), psram_pkg::WR_WORDS, beats);
		if (read_waits) begin
			arvalid <= 1'b0;
			check_value($sformatf("%s bvalid pulses before arready", name), 1, bresp);
		end
		for (int i = 0; i < psram_pkg::WR_WORDS; i++)
			sb[base + 23'(i)] = seed + 16'(i);
	endtask

	task automatic collect_read(input string name, input logic [23:0] addr);
		int n;
		logic [22:0] base;
		logic [15:0] w;
		n = 0;
		base = {addr[23:3], 2'b00};
		while (n < psram_pkg::RD_WORDS) begin
			@(posedge clk);
			if (rvalid) begin
				if (!sb.exists(base + 23'(n))) begin
					errors++;
					$display("%s read a word that was never written", name);
				end else begin
					w = sb[base + 23'(n)];
					check_value($sformatf("%s word %0d", name, n),
						{1'b0, w[15:8], 1'b0, w[7:0]}, rdata);
				end
				n++;
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		logic [7:0] boot_cmds [5];
		logic [23:0] a;
		logic [23:0] last_rand;
		op_row_t r;
		int cycles;
		int n0;
		int writes;
		int reads;
		reset <= 1'b1;
		awaddr <= '0;
		awvalid <= 1'b0;
		araddr <= '0;
		arvalid <= 1'b0;
		wdata <= '0;
		boot_cmds = '{psram_pkg::OPC_RESET_EN, psram_pkg::OPC_RESET, psram_pkg::OPC_WRITE_EN,
			psram_pkg::OPC_WRITE_REG, psram_pkg::OPC_WRITE_EN};
		last_rand = '0;
		writes = 0;
		reads = 0;
		lfsr = 16'd16;
		build_table();
		table_done = 1'b1;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		check_value("idle outputs after reset", 0, {psram_ready, awready, arready, wready,
			bvalid, rvalid, pads.cs, pads.data_oe, pads.rwds_oe});

		// Startup wait, reset and latency config
		cycles = 0;
		while (!psram_ready) begin
			@(posedge clk);
			cycles++;
		end
		check_value("startup wait long enough", 1, cycles >= psram_pkg::STARTUP_CYCLES);
		check_value("startup command count", 5, model_i.cmd_log.size());
		for (int i = 0; i < 5; i++)
			check_value($sformatf("startup command %0d", i), boot_cmds[i], model_i.cmd_log[i]);
		check_value("config byte count", 2, model_i.cfg_bytes.size());
		check_value("config high byte", psram_pkg::CR0_VALUE[15:8], model_i.cfg_bytes[0]);
		check_value("config low byte", psram_pkg::CR0_VALUE[7:0], model_i.cfg_bytes[1]);

		foreach (rows[i]) begin
			r = rows[i];
			a = r.addr;
			if (r.rand_addr && r.kind == K_WRITE) begin
				random_bits(24, a);
				last_rand = a;
			end else if (r.rand_addr) begin
				a = last_rand;
			end
			n0 = model_i.cmd_log.size();
			case (r.kind)
				K_WRITE: begin
					send_request(names[i], 1'b1, 1'b0, a, r.seed);
					serve_write(names[i], a, r.seed, 1'b0);
					writes++;
				end
				K_READ: begin
					send_request(names[i], 1'b0, 1'b1, a, r.seed);
					collect_read(names[i], a);
					reads++;
				end
				default: begin
					send_request(names[i], 1'b1, 1'b1, a, r.seed);
					serve_write(names[i], a, r.seed, 1'b1);
					check_value($sformatf("%s first command", names[i]), psram_pkg::OPC_WRITE,
						model_i.cmd_log[n0]);
					collect_read(names[i], a);
					writes++;
					reads++;
				end
			endcase
		end

		// Let any stray pulse show up in the totals
		repeat (8) @(posedge clk);
		check_value("total bvalid pulses", writes, bvalid_total);
		check_value("total rvalid pulses", reads * psram_pkg::RD_WORDS, rvalid_total);

		$display("Checks run %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: files.f
psram_pkg.sv
psram_sequencer.sv
psram_wave_table.sv
psram_step_engine.sv
psram_phase_serializer.sv
psram_read_capture.sv
psram_ctrl.sv
psram_model.sv
tb_psram_ctrl.sv

// File: Makefile
TOP = tb_psram_ctrl

sim:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		-f files.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
